// ==== Bender.yml ====
package:
  name: bchDecoder

sources:
  - logic/bchPkg.sv
  - logic/bchControl.sv
  - logic/bchSyndrome.sv
  - logic/bchLocator.sv
  - logic/bchChien.sv
  - logic/bchDelayLine.sv
  - logic/bchDecoder.sv
  - target: simulation
    files:
      - dv/bchDecoder_checker.sv
      - dv/bchDecoderTb.sv

// ==== dv/bchDecoderTb.sv ====
`timescale 1ns/1ps

module bchDecoderTb;

	localparam int clkPeriod = 100;
	localparam int resetCycles = 16;
	localparam logic [14:0] genPoly = 15'h1d1; // x^8 + x^7 + x^6 + x^4 + 1.

	logic clk;
	logic arstN;
	logic din;
	logic dout;
	logic vdout;
	logic [31:0] lfsr;
	logic [14:0] frames[$];
	logic expBits[$];
	int expTest[$];
	string testNames[$];
	bit loaded;

	bchDecoder i_bchDecoder (.clk(clk), .arstN(arstN), .din(din), .dout(dout), .vdout(vdout));

	bind bchDecoder bchDecoderChecker i_bchDecoderChecker (
		.clk(clk), .arstN(arstN), .dout(dout), .vdout(vdout));

	always #(clkPeriod / 2) clk = ~clk;

	// galois form of x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsrNext(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic drawBits(input int n, output int value);
		value = 0;
		for (int i = 0; i < n; i++) begin
			value = (value << 1) | int'(lfsr[0]);
			lfsr = lfsrNext(lfsr); // one step per bit taken.
		end
	endtask

	// message on x^14..x^8, remainder of m(x) x^8 / g(x) below it.
	function automatic logic [14:0] encodeMessage(logic [6:0] msg);
		logic [14:0] rem;
		rem = {msg, 8'b0};
		for (int i = 14; i >= 8; i--) begin
			if (rem[i])
				rem ^= genPoly << (i - 8);
		end
		return {msg, rem[7:0]};
	endfunction

	// position p is sent p-th and carries x^(14-p).
	task automatic injectErrors(inout logic [14:0] cw, input int n, input int lo, input int hi);
		logic [14:0] used;
		int p;
		used = '0;
		while (n > 0) begin
			drawBits(4, p);
			if (p <= 14 && p >= lo && p <= hi && !used[p]) begin
				used[p] = 1'b1;
				cw[14 - p] = ~cw[14 - p];
				n--;
			end
		end
	endtask

	task automatic loadVectors();
		int fd;
		string line;
		string name;
		logic [6:0] msg;
		int nErr;
		int lo;
		int hi;
		logic [14:0] cw;
		fd = $fopen("dv/bch_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open the test data file dv/bch_testdata.txt");
			$display("Test FAILED");
			$fatal(1, "no test data");
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			if ($sscanf(line, "%s %h %d %d %d", name, msg, nErr, lo, hi) != 5
					|| nErr > hi - lo + 1) begin
				$display("malformed test data line: %s", line);
				$display("Test FAILED");
				$fatal(1, "bad test data");
			end
			cw = encodeMessage(msg);
			injectErrors(cw, nErr, lo, hi);
			frames.push_back(cw);
			for (int i = bchPkg::msgLen - 1; i >= 0; i--) begin
				expBits.push_back(msg[i]); // message leaves highest bit first.
				expTest.push_back(testNames.size());
			end
			testNames.push_back(name);
		end
		$fclose(fd);
		repeat (2) frames.push_back('0); // flush the two-frame pipeline.
	endtask

	initial begin
		clk = 1'b0;
		arstN = 1'b0;
		din = 1'b0;
		lfsr = 32'h4b8a;
		loaded = 1'b0;
		loadVectors();
		loaded = 1'b1;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1; // bit 0 of frame 0 goes out with the release.
		foreach (frames[f]) begin
			for (int i = bchPkg::codeLen - 1; i >= 0; i--) begin
				din = frames[f][i];
				@(negedge clk);
			end
		end
		din = 1'b0;
		while (expBits.size() != 0)
			@(negedge clk);
		if (i_bchDecoder.i_bchDecoderChecker.failCount != 0) begin
			$display("an assertion on vdout or dout failed in the bound checker");
			$display("Test FAILED");
			$fatal(1, "checker assertion failed");
		end else begin
			$display("Test OK");
			$finish;
		end
	end

	// outputs change on the rising edge, so they are sampled on the falling one.
	always @(negedge clk) begin
		assert (i_bchDecoder.i_bchDecoderChecker.failCount == 0) else begin
			$display("an assertion on vdout or dout failed in the bound checker");
			$display("Test FAILED");
			$fatal(1, "checker assertion failed");
		end
		if (arstN && vdout && expBits.size() > 0) begin
			assert (dout === expBits[0]) else begin
				$display("error %s: expected %0b, actual %0b",
					testNames[expTest[0]], expBits[0], dout);
				$display("Test FAILED");
				$fatal(1, "decoded bit mismatch");
			end
			void'(expBits.pop_front());
			void'(expTest.pop_front());
		end
	end

	initial begin
		int limitNs;
		wait (loaded);
		limitNs = (frames.size() + 4) * bchPkg::codeLen * clkPeriod + resetCycles * clkPeriod;
		#(limitNs);
		$display("timeout: the decoder did not deliver all messages in time");
		$display("Test FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== dv/bchDecoder_checker.sv ====
`timescale 1ns/1ps

module bchDecoderChecker (
	input logic clk,
	input logic arstN,
	input logic dout,
	input logic vdout
);

	logic [5:0] cycQ;
	int failCount = 0; // failed assertions so far.

	// cycles since reset release, saturating.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			cycQ <= '0;
		end else if (cycQ != 6'h3f) begin
			cycQ <= cycQ + 6'd1;
		end
	end

	// first decoded frame needs two full frames plus the output register.
	quietStart: assert property (@(posedge clk) disable iff (!arstN) (cycQ < 6'd31) |-> !vdout)
		else begin
			$error("vdout raised before the first frame was decoded");
			failCount++;
		end

	burstShape: assert property (@(posedge clk) disable iff (!arstN)
		$rose(vdout) |-> vdout[*7] ##1 !vdout[*8] ##1 vdout)
		else begin
			$error("vdout is not 7 cycles high out of every 15");
			failCount++;
		end

	knownData: assert property (@(posedge clk) disable iff (!arstN) vdout |-> !$isunknown(dout))
		else begin
			$error("dout unknown while vdout is high");
			failCount++;
		end

	quietData: assert property (@(posedge clk) disable iff (!arstN) !vdout |-> !dout)
		else begin
			$error("dout high while vdout is low");
			failCount++;
		end

endmodule

// ==== dv/bch_testdata.txt ====
# columns: test name, message (7-bit hex), errors to inject, lowest and highest error position
# position 0 is the first bit sent, 0..6 carry the message, 7..14 the parity
clean00 00 0 0 14
clean7f 7f 0 0 14
clean55 55 0 0 14
clean2a 2a 0 0 14
single1 13 1 0 14
single2 6c 1 0 14
singleFirst 41 1 0 0
singleLast 3e 1 14 14
singleMid 08 1 7 7
single3 5a 1 0 14
double1 27 2 0 14
double2 71 2 0 14
double3 0f 2 0 14
doubleData 1c 2 0 6
parity1 4d 1 8 14
parity2 32 2 8 14
parity3 7f 2 8 14
mixed0 19 0 0 14
mixed2 55 2 0 14
mixed1 2b 1 0 14
mixed2b 00 2 0 14
mixed0b 7e 0 0 14

// ==== logic/bchChien.sv ====
`timescale 1ns/1ps

module bchChien (
	input logic clk,
	input logic arstN,
	input logic [3:0] pos,
	input bchPkg::locatorT loc,
	output logic errFlag
);

	bchPkg::gfElem pendS1Q;
	bchPkg::gfElem pendS2Q;
	bchPkg::gfElem r1Q;
	bchPkg::gfElem r2Q;
	bchPkg::gfElem r1Cur;
	bchPkg::gfElem r2Cur;
	logic frameStart;

	assign frameStart = (pos == 4'd0);

	// locator arrives mid-frame, parked until the next frame starts.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pendS1Q <= '0;
			pendS2Q <= '0;
		end else if (loc.valid) begin
			pendS1Q <= loc.sigma1;
			pendS2Q <= loc.sigma2;
		end
	end

	// at pos 0 the terms come straight from the parked coefficients.
	assign r1Cur = frameStart ? bchPkg::gfMul(pendS1Q, bchPkg::alphaPow(1)) : r1Q;
	assign r2Cur = frameStart ? bchPkg::gfMul(pendS2Q, bchPkg::alphaPow(2)) : r2Q;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			r1Q <= '0;
			r2Q <= '0;
		end else begin
			r1Q <= bchPkg::gfMul(r1Cur, bchPkg::alphaPow(1));
			r2Q <= bchPkg::gfMul(r2Cur, bchPkg::alphaPow(2));
		end
	end

	// sigma(alpha^(pos+1)) == 0 marks an error at alpha^(14-pos).
	assign errFlag = ((4'b0001 ^ r1Cur ^ r2Cur) == '0);

endmodule

// ==== logic/bchControl.sv ====
`timescale 1ns/1ps

module bchControl (
	input logic clk,
	input logic arstN,
	output logic [3:0] pos,
	output logic frameEnd,
	output logic outEn
);

	logic [3:0] posQ;
	logic [1:0] frameCntQ;

	// bit position within the frame, 0 is the first bit after reset.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			posQ <= '0;
		end else if (posQ == 4'(bchPkg::codeLen - 1)) begin
			posQ <= '0;
		end else begin
			posQ <= posQ + 4'd1;
		end
	end

	// counts the first two frames, then sits at 2.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			frameCntQ <= '0;
		end else if (frameEnd && frameCntQ != 2'd2) begin
			frameCntQ <= frameCntQ + 2'd1;
		end
	end

	assign pos = posQ;
	assign frameEnd = (posQ == 4'(bchPkg::codeLen - 1));
	assign outEn = (frameCntQ == 2'd2); // first decoded frame reaches the output.

endmodule

// ==== logic/bchDecoder.sv ====
`timescale 1ns/1ps

module bchDecoder (
	input logic clk,
	input logic arstN,
	input logic din,
	output logic dout,
	output logic vdout
);

	logic [3:0] pos;
	logic frameEnd;
	logic outEn;
	logic errFlag;
	logic dly;
	logic msgSlot;
	bchPkg::syndromeT syn;
	bchPkg::locatorT loc;

	bchControl i_bchControl (
		.clk(clk),
		.arstN(arstN),
		.pos(pos),
		.frameEnd(frameEnd),
		.outEn(outEn)
	);

	bchSyndrome i_bchSyndrome (
		.clk(clk),
		.arstN(arstN),
		.din(din),
		.frameEnd(frameEnd),
		.syn(syn)
	);

	bchLocator i_bchLocator (
		.clk(clk),
		.arstN(arstN),
		.syn(syn),
		.loc(loc)
	);

	bchChien i_bchChien (
		.clk(clk),
		.arstN(arstN),
		.pos(pos),
		.loc(loc),
		.errFlag(errFlag)
	);

	bchDelayLine i_bchDelayLine (
		.clk(clk),
		.arstN(arstN),
		.din(din),
		.dly(dly)
	);

	// only the message part of a frame leaves the decoder.
	assign msgSlot = outEn && (pos < 4'(bchPkg::msgLen));

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			dout <= 1'b0;
			vdout <= 1'b0;
		end else begin
			vdout <= msgSlot;
			dout <= (dly ^ errFlag) && msgSlot; // low outside valid.
		end
	end

endmodule

// ==== logic/bchDelayLine.sv ====
`timescale 1ns/1ps

module bchDelayLine (
	input logic clk,
	input logic arstN,
	input logic din,
	output logic dly
);

	logic [bchPkg::latency-1:0] shiftQ;

	// newest bit enters at index 0.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			shiftQ <= '0;
		end else begin
			shiftQ <= {shiftQ[bchPkg::latency-2:0], din};
		end
	end

	assign dly = shiftQ[bchPkg::latency-1]; // same frame slot, two frames back.

endmodule

// ==== logic/bchLocator.sv ====
`timescale 1ns/1ps

module bchLocator (
	input logic clk,
	input logic arstN,
	input bchPkg::syndromeT syn,
	output bchPkg::locatorT loc
);

	bchPkg::locState stateQ;
	bchPkg::gfElem s1Q;
	bchPkg::gfElem s3Q;
	bchPkg::gfElem sumQ;
	bchPkg::gfElem invQ;
	bchPkg::gfElem sigma1Q;
	bchPkg::gfElem sigma2Q;
	logic validQ;

	// fixed walk through the states, one per cycle.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			stateQ <= bchPkg::idle;
			validQ <= 1'b0;
		end else begin
			case (stateQ)
				bchPkg::idle: begin
					if (syn.valid)
						stateQ <= bchPkg::cube;
				end
				bchPkg::cube: begin
					stateQ <= bchPkg::invert;
				end
				bchPkg::invert: begin
					stateQ <= bchPkg::divide;
				end
				bchPkg::divide: begin
					stateQ <= bchPkg::done;
					validQ <= 1'b1; // high while in done.
				end
				default: begin
					stateQ <= bchPkg::idle;
					validQ <= 1'b0;
				end
			endcase
		end
	end

	// peterson solution: sigma1 = s1, sigma2 = (s3 + s1^3) / s1.
	always_ff @(posedge clk) begin
		case (stateQ)
			bchPkg::idle: begin
				if (syn.valid) begin
					s1Q <= syn.s1;
					s3Q <= syn.s3;
				end
			end
			bchPkg::cube: begin
				sumQ <= s3Q ^ bchPkg::gfMul(bchPkg::gfSquare(s1Q), s1Q);
			end
			bchPkg::invert: begin
				invQ <= bchPkg::gfInv(s1Q);
			end
			bchPkg::divide: begin
				if (s1Q == '0) begin
					// no usable locator, leave the frame untouched.
					sigma1Q <= '0;
					sigma2Q <= '0;
				end else begin
					sigma1Q <= s1Q;
					sigma2Q <= bchPkg::gfMul(sumQ, invQ);
				end
			end
			default: ;
		endcase
	end

	assign loc = '{sigma1: sigma1Q, sigma2: sigma2Q, valid: validQ};

endmodule

// ==== logic/bchPkg.sv ====
package bchPkg;

	localparam int codeLen = 15;
	localparam int msgLen = 7;
	localparam int fieldWidth = 4;
	localparam int latency = 2 * codeLen; // din to dly, two full frames.

	// bit i holds the coefficient of x^i.
	typedef logic [fieldWidth-1:0] gfElem;

	// x^4 folds back to x + 1.
	localparam gfElem primLow = 4'b0011;

	typedef struct packed {
		gfElem s1;
		gfElem s3;
		logic valid;
	} syndromeT;

	typedef struct packed {
		gfElem sigma1;
		gfElem sigma2;
		logic valid;
	} locatorT;

	typedef enum logic [2:0] {
		idle,
		cube,
		invert,
		divide,
		done
	} locState;

	function automatic gfElem gfMul(gfElem a, gfElem b);
		gfElem acc;
		gfElem sh;
		acc = '0;
		sh = a;
		for (int i = 0; i < fieldWidth; i++) begin
			if (b[i])
				acc ^= sh;
			sh = {sh[fieldWidth-2:0], 1'b0} ^ (sh[fieldWidth-1] ? primLow : '0);
		end
		return acc;
	endfunction

	// squaring is linear: x^4 -> x + 1, x^6 -> x^3 + x^2.
	function automatic gfElem gfSquare(gfElem a);
		return {a[3], a[1] ^ a[3], a[2], a[0] ^ a[2]};
	endfunction

	// a^14 = a^2 * a^4 * a^8, zero maps to zero.
	function automatic gfElem gfInv(gfElem a);
		gfElem a2;
		gfElem a4;
		gfElem a8;
		a2 = gfSquare(a);
		a4 = gfSquare(a2);
		a8 = gfSquare(a4);
		return gfMul(gfMul(a2, a4), a8);
	endfunction

	function automatic gfElem alphaPow(int n);
		gfElem e;
		e = 4'b0001;
		for (int i = 0; i < codeLen; i++) begin
			if (i < n)
				e = gfMul(e, 4'b0010);
		end
		return e;
	endfunction

endpackage

// ==== logic/bchSyndrome.sv ====
`timescale 1ns/1ps

module bchSyndrome (
	input logic clk,
	input logic arstN,
	input logic din,
	input logic frameEnd,
	output bchPkg::syndromeT syn
);

	bchPkg::gfElem acc1Q;
	bchPkg::gfElem acc3Q;
	bchPkg::gfElem next1;
	bchPkg::gfElem next3;
	bchPkg::gfElem dinElem;
	bchPkg::gfElem s1Q;
	bchPkg::gfElem s3Q;
	logic validQ;

	assign dinElem = {{(bchPkg::fieldWidth - 1){1'b0}}, din};

	// horner step, highest coefficient arrives first.
	assign next1 = bchPkg::gfMul(acc1Q, bchPkg::alphaPow(1)) ^ dinElem; // r(alpha).
	assign next3 = bchPkg::gfMul(acc3Q, bchPkg::alphaPow(3)) ^ dinElem; // r(alpha^3).

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			acc1Q <= '0;
			acc3Q <= '0;
			validQ <= 1'b0;
		end else begin
			validQ <= frameEnd;
			if (frameEnd) begin
				acc1Q <= '0; // next frame starts clean.
				acc3Q <= '0;
			end else begin
				acc1Q <= next1;
				acc3Q <= next3;
			end
		end
	end

	// held until the end of the following frame.
	always_ff @(posedge clk) begin
		if (frameEnd) begin
			s1Q <= next1;
			s3Q <= next3;
		end
	end

	assign syn = '{s1: s1Q, s3: s3Q, valid: validQ};

endmodule

// ==== sim.f ====
logic/bchPkg.sv
logic/bchControl.sv
logic/bchSyndrome.sv
logic/bchLocator.sv
logic/bchChien.sv
logic/bchDelayLine.sv
logic/bchDecoder.sv
dv/bchDecoder_checker.sv
dv/bchDecoderTb.sv
